// ==== include/index_gen_cfg.svh ====
// Width and FIFO sizing macros for the CSR index generator.
// Included by the package, the request FIFO and the testbench.

`ifndef INDEX_GEN_CFG_SVH
`define INDEX_GEN_CFG_SVH

// ---------------------------------------------------------------------------
// Data widths
// ---------------------------------------------------------------------------

// Index and offset words
`define INDEX_WIDTH 32

// Array pointer and request base
`define ADDR_WIDTH 64

// Covers any shift of a 32 bit index
`define SHIFT_WIDTH 5

// ---------------------------------------------------------------------------
// Request FIFO sizing
// ---------------------------------------------------------------------------

`define FIFO_DEPTH 16

// Kept well below the depth to absorb in-flight pushes
`define FIFO_PROG_THRESH 8

`endif

// ==== source/index_gen_pkg.sv ====
// Shared types of the CSR index generator.
// Modules name these types in their ports and import the package in their body.

`include "index_gen_cfg.svh"

package index_gen_pkg;

    typedef logic [`INDEX_WIDTH-1:0] index_t;
    typedef logic [`ADDR_WIDTH-1:0]  addr_t;
    typedef logic [`SHIFT_WIDTH-1:0] shift_amt_t;

    // Control FSM states
    typedef enum logic [3:0] {
        RESET,
        IDLE,
        SETUP_IDLE,
        SETUP_TRANS,
        SETUP,
        START_TRANS,
        START,
        BUSY,
        BUSY_TRANS,
        PAUSE_TRANS,
        PAUSE,
        DONE
    } index_gen_state_t;

endpackage : index_gen_pkg

// ==== source/index_gen_control.sv ====
// Control FSM of the CSR index generator.
// Fetches one configuration word per start, holds it, and steers the
// sequencer through run and pause until the last index is produced.

`timescale 1ns/1ps

module index_gen_control (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  logic                      start,
    input  logic                      cfg_ready,
    input  logic                      cfg_valid,
    input  index_gen_pkg::index_t     cfg_index_start,
    input  index_gen_pkg::index_t     cfg_index_end,
    input  index_gen_pkg::index_t     cfg_stride,
    input  index_gen_pkg::addr_t      cfg_array_pointer,
    input  logic                      cfg_shift_left,
    input  index_gen_pkg::shift_amt_t cfg_shift_amount,
    input  logic                      last,
    input  logic                      prog_full,
    output logic                      cfg_request,
    output logic                      load,
    output logic                      run,
    output logic                      done,
    output index_gen_pkg::index_t     index_start,
    output index_gen_pkg::index_t     index_end,
    output index_gen_pkg::index_t     stride,
    output index_gen_pkg::addr_t      array_pointer,
    output logic                      shift_left,
    output index_gen_pkg::shift_amt_t shift_amount
);

    import index_gen_pkg::*;

    index_gen_state_t current_state;
    index_gen_state_t next_state;

    // ---------------------------------------------------------------------------
    // State register and next state
    // ---------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            current_state <= RESET;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            RESET:       next_state = IDLE;
            IDLE:        if (start) next_state = SETUP_IDLE;
            SETUP_IDLE:  if (cfg_ready) next_state = SETUP_TRANS;
            SETUP_TRANS: next_state = SETUP;
            SETUP:       if (cfg_valid) next_state = START_TRANS;
            START_TRANS: next_state = START;
            START:       next_state = BUSY;
            BUSY: begin
                // End of range wins over back-pressure
                if (last) begin
                    next_state = DONE;
                end else if (prog_full) begin
                    next_state = PAUSE_TRANS;
                end
            end
            BUSY_TRANS:  next_state = BUSY;
            PAUSE_TRANS: next_state = PAUSE;
            PAUSE:       if (!prog_full) next_state = BUSY_TRANS;
            DONE:        next_state = start ? SETUP_IDLE : IDLE;
            default:     next_state = RESET;
        endcase
    end

    // ---------------------------------------------------------------------------
    // Registered outputs per state
    // ---------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            cfg_request <= 1'b0;
            load        <= 1'b0;
            run         <= 1'b0;
            done        <= 1'b1;
        end else begin
            cfg_request <= 1'b0;
            load        <= 1'b0;
            case (current_state)
                SETUP_TRANS: cfg_request <= 1'b1;
                START_TRANS: begin
                    load <= 1'b1;
                    done <= 1'b0;
                end
                BUSY, BUSY_TRANS: begin
                    run  <= 1'b1;
                    done <= 1'b0;
                end
                PAUSE_TRANS, PAUSE: run <= 1'b0;
                START:              run <= 1'b0;
                default: begin
                    // Idle, setup and done states
                    run  <= 1'b0;
                    done <= 1'b1;
                end
            endcase
        end
    end

    // Configuration word, held until the next fetch
    always_ff @(posedge ap_clk) begin
        if (current_state == SETUP && cfg_valid) begin
            index_start   <= cfg_index_start;
            index_end     <= cfg_index_end;
            stride        <= cfg_stride;
            array_pointer <= cfg_array_pointer;
            shift_left    <= cfg_shift_left;
            shift_amount  <= cfg_shift_amount;
        end
    end

endmodule : index_gen_control

// ==== source/index_sequencer.sv ====
// Index counter and request formatting.
// Steps from the loaded start by the stride while run is high and the
// count is below the end, and registers one request word per index.

`timescale 1ns/1ps

module index_sequencer (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  logic                      load,
    input  logic                      run,
    input  index_gen_pkg::index_t     index_start,
    input  index_gen_pkg::index_t     index_end,
    input  index_gen_pkg::index_t     stride,
    input  index_gen_pkg::addr_t      array_pointer,
    input  logic                      shift_left,
    input  index_gen_pkg::shift_amt_t shift_amount,
    output logic                      last,
    output logic                      push,
    output index_gen_pkg::addr_t      push_base,
    output index_gen_pkg::index_t     push_offset,
    output index_gen_pkg::index_t     push_index
);

    import index_gen_pkg::*;

    index_t                   count;
    logic [$bits(index_t):0]  count_sum;
    index_t                   offset;
    logic                     advance;

    // ---------------------------------------------------------------------------
    // Counter
    // ---------------------------------------------------------------------------

    // Single end-of-range test, shared by push and control
    assign last    = (count >= index_end);
    assign advance = run && !last;

    // Extra bit catches a wrap past the top of the index range
    assign count_sum = {1'b0, count} + {1'b0, stride};

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            count <= '0;
        end else if (load) begin
            count <= index_start;
        end else if (advance) begin
            // Saturate on wrap so the count stays at or above the end
            if (count_sum[$bits(index_t)]) begin
                count <= '1;
            end else begin
                count <= count_sum[$bits(index_t)-1:0];
            end
        end
    end

    // ---------------------------------------------------------------------------
    // Request word
    // ---------------------------------------------------------------------------
    always_comb begin
        if (shift_left) begin
            offset = count << shift_amount;
        end else begin
            offset = count >> shift_amount;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            push <= 1'b0;
        end else begin
            push <= advance;
        end
    end

    always_ff @(posedge ap_clk) begin
        push_base   <= array_pointer;
        push_offset <= offset;
        push_index  <= count;
    end

endmodule : index_sequencer

// ==== source/request_fifo.sv ====
// Synchronous request FIFO with a programmable-full flag.
// A pop on a non-empty FIFO returns the oldest entry with req_valid
// on the following cycle.

`timescale 1ns/1ps

`include "index_gen_cfg.svh"

module request_fifo #(
    parameter int DEPTH       = `FIFO_DEPTH,
    parameter int PROG_THRESH = `FIFO_PROG_THRESH
) (
    input  logic                  ap_clk,
    input  logic                  areset_generator,
    input  logic                  push,
    input  index_gen_pkg::addr_t  push_base,
    input  index_gen_pkg::index_t push_offset,
    input  index_gen_pkg::index_t push_index,
    input  logic                  rd_en,
    output logic                  req_valid,
    output index_gen_pkg::addr_t  req_base,
    output index_gen_pkg::index_t req_offset,
    output index_gen_pkg::index_t req_index,
    output logic                  prog_full,
    output logic                  empty
);

    import index_gen_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    addr_t  base_mem   [DEPTH];
    index_t offset_mem [DEPTH];
    index_t index_mem  [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             wr;
    logic             rd;

    assign full      = (count == CNT_W'(DEPTH));
    assign empty     = (count == '0);
    assign prog_full = (count >= CNT_W'(PROG_THRESH));

    // Writes to a full FIFO are dropped, pops on empty are ignored
    assign wr = push && !full;
    assign rd = rd_en && !empty;

    // ---------------------------------------------------------------------------
    // Pointers and occupancy
    // ---------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            req_valid <= 1'b0;
        end else begin
            if (wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr && !rd) begin
                count <= count + 1'b1;
            end else if (rd && !wr) begin
                count <= count - 1'b1;
            end
            req_valid <= rd;
        end
    end

    // Storage and read data
    always_ff @(posedge ap_clk) begin
        if (wr) begin
            base_mem[wr_ptr]   <= push_base;
            offset_mem[wr_ptr] <= push_offset;
            index_mem[wr_ptr]  <= push_index;
        end
        if (rd) begin
            req_base   <= base_mem[rd_ptr];
            req_offset <= offset_mem[rd_ptr];
            req_index  <= index_mem[rd_ptr];
        end
    end

endmodule : request_fifo

// ==== source/csr_index_generator.sv ====
// Top level of the CSR index generator.
// Registers the reset and connects control, sequencer and request FIFO.

`timescale 1ns/1ps

module csr_index_generator (
    input  logic                      ap_clk,
    input  logic                      areset,
    input  logic                      start,
    input  logic                      cfg_ready,
    input  logic                      cfg_valid,
    input  index_gen_pkg::index_t     cfg_index_start,
    input  index_gen_pkg::index_t     cfg_index_end,
    input  index_gen_pkg::index_t     cfg_stride,
    input  index_gen_pkg::addr_t      cfg_array_pointer,
    input  logic                      cfg_shift_left,
    input  index_gen_pkg::shift_amt_t cfg_shift_amount,
    output logic                      cfg_request,
    input  logic                      req_rd_en,
    output logic                      req_valid,
    output index_gen_pkg::addr_t      req_base,
    output index_gen_pkg::index_t     req_offset,
    output index_gen_pkg::index_t     req_index,
    output logic                      done
);

    import index_gen_pkg::*;

    logic       areset_generator;
    logic       load;
    logic       run;
    logic       last;
    logic       prog_full;
    index_t     index_start;
    index_t     index_end;
    index_t     stride;
    addr_t      array_pointer;
    logic       shift_left;
    shift_amt_t shift_amount;
    logic       push;
    addr_t      push_base;
    index_t     push_offset;
    index_t     push_index;

    // One register stage on the reset, shared by all blocks
    always_ff @(posedge ap_clk) begin
        areset_generator <= areset;
    end

    // ---------------------------------------------------------------------------
    // Blocks
    // ---------------------------------------------------------------------------
    index_gen_control i_index_gen_control (
        .ap_clk            (ap_clk),
        .areset_generator  (areset_generator),
        .start             (start),
        .cfg_ready         (cfg_ready),
        .cfg_valid         (cfg_valid),
        .cfg_index_start   (cfg_index_start),
        .cfg_index_end     (cfg_index_end),
        .cfg_stride        (cfg_stride),
        .cfg_array_pointer (cfg_array_pointer),
        .cfg_shift_left    (cfg_shift_left),
        .cfg_shift_amount  (cfg_shift_amount),
        .last              (last),
        .prog_full         (prog_full),
        .cfg_request       (cfg_request),
        .load              (load),
        .run               (run),
        .done              (done),
        .index_start       (index_start),
        .index_end         (index_end),
        .stride            (stride),
        .array_pointer     (array_pointer),
        .shift_left        (shift_left),
        .shift_amount      (shift_amount)
    );

    index_sequencer i_index_sequencer (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .load             (load),
        .run              (run),
        .index_start      (index_start),
        .index_end        (index_end),
        .stride           (stride),
        .array_pointer    (array_pointer),
        .shift_left       (shift_left),
        .shift_amount     (shift_amount),
        .last             (last),
        .push             (push),
        .push_base        (push_base),
        .push_offset      (push_offset),
        .push_index       (push_index)
    );

    // Empty flag is only needed inside the FIFO for pop gating
    request_fifo i_request_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (push),
        .push_base        (push_base),
        .push_offset      (push_offset),
        .push_index       (push_index),
        .rd_en            (req_rd_en),
        .req_valid        (req_valid),
        .req_base         (req_base),
        .req_offset       (req_offset),
        .req_index        (req_index),
        .prog_full        (prog_full),
        .empty            ()
    );

endmodule : csr_index_generator

// ==== tb/csr_index_generator_tb.sv ====
// Self-checking testbench for the CSR index generator.
// Reads one test per line from tb/index_gen_cases.txt, answers the configuration
// fetch, pops the request FIFO and compares every popped request.

`timescale 1ns/1ps

`include "index_gen_cfg.svh"

module csr_index_generator_tb;

    import index_gen_pkg::*;

    localparam int CLK_PERIOD_NS   = 100;
    localparam int RESET_CYCLES    = 16;
    localparam int MAX_CASES       = 32;
    localparam int CYCLES_PER_ITEM = 8;
    localparam int CYCLES_PER_TEST = 64;
    localparam int NEWLINE         = 10;

    logic       ap_clk;
    logic       areset;
    logic       start;
    logic       cfg_ready;
    logic       cfg_valid;
    index_t     cfg_index_start;
    index_t     cfg_index_end;
    index_t     cfg_stride;
    addr_t      cfg_array_pointer;
    logic       cfg_shift_left;
    shift_amt_t cfg_shift_amount;
    logic       cfg_request;
    logic       req_rd_en;
    logic       req_valid;
    addr_t      req_base;
    index_t     req_offset;
    index_t     req_index;
    logic       done;

    // Case table
    string       case_name    [MAX_CASES];
    index_t      case_start   [MAX_CASES];
    index_t      case_end     [MAX_CASES];
    index_t      case_stride  [MAX_CASES];
    addr_t       case_pointer [MAX_CASES];
    logic        case_left    [MAX_CASES];
    shift_amt_t  case_amount  [MAX_CASES];
    logic [31:0] case_pop     [MAX_CASES];
    int          num_cases;
    logic        cases_loaded;
    int          watchdog_cycles;

    // State of the running test
    string            test_name;
    addr_t            cur_pointer;
    logic             cur_left;
    shift_amt_t       cur_amount;
    index_t           expected_q[$];
    int               received;
    int               cfg_pulses;
    int               hold_left;
    logic             pop_random;
    int               error_count;
    int               failed_tests;
    logic [31:0]      lfsr_state;
    index_gen_state_t fsm_state;

    assign fsm_state = i_csr_index_generator.i_index_gen_control.current_state;

    csr_index_generator i_csr_index_generator (
        .ap_clk            (ap_clk),
        .areset            (areset),
        .start             (start),
        .cfg_ready         (cfg_ready),
        .cfg_valid         (cfg_valid),
        .cfg_index_start   (cfg_index_start),
        .cfg_index_end     (cfg_index_end),
        .cfg_stride        (cfg_stride),
        .cfg_array_pointer (cfg_array_pointer),
        .cfg_shift_left    (cfg_shift_left),
        .cfg_shift_amount  (cfg_shift_amount),
        .cfg_request       (cfg_request),
        .req_rd_en         (req_rd_en),
        .req_valid         (req_valid),
        .req_base          (req_base),
        .req_offset        (req_offset),
        .req_index         (req_index),
        .done              (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) ap_clk = ~ap_clk;
    end

    // ---------------------------------------------------------------------------
    // Reference model and helpers
    // ---------------------------------------------------------------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // Indices start, start+stride, ... kept strictly below the end
    function automatic int item_count(input index_t first, input index_t limit,
                                      input index_t step);
        logic [`INDEX_WIDTH:0] idx;
        int                    n;
        idx = {1'b0, first};
        n   = 0;
        while (idx < {1'b0, limit} && step != '0) begin
            n++;
            idx = idx + {1'b0, step};
        end
        return n;
    endfunction

    task automatic check_value(input string field, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic take_request();
        index_t exp_index;
        index_t exp_offset;
        if (expected_q.size() == 0) begin
            $display("Unexpected request in test %s: index %h came after all expected ones",
                     test_name, req_index);
            error_count++;
        end else begin
            exp_index  = expected_q.pop_front();
            exp_offset = cur_left ? (exp_index << cur_amount) : (exp_index >> cur_amount);
            check_value("index", exp_index, req_index);
            check_value("base", cur_pointer, req_base);
            check_value("offset", exp_offset, req_offset);
            received++;
        end
    endtask

    // Sample outputs on the falling edge, then drive the pop strobe
    task automatic cycle_step();
        @(negedge ap_clk);
        if (req_valid === 1'b1) begin
            take_request();
        end
        if (cfg_request === 1'b1) begin
            cfg_pulses++;
        end
        if (hold_left > 0) begin
            hold_left--;
            req_rd_en = 1'b0;
        end else if (pop_random) begin
            lfsr_state = lfsr_step(lfsr_state);
            req_rd_en  = lfsr_state[0];
        end else begin
            req_rd_en = 1'b1;
        end
    endtask

    task automatic load_cases();
        int    fd;
        int    c;
        int    n;
        string word;
        num_cases = 0;
        fd = $fopen("tb/index_gen_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tb/index_gen_cases.txt from the working directory");
            error_count++;
            return;
        end
        while (num_cases < MAX_CASES && $fscanf(fd, "%s", word) == 1) begin
            if (word.substr(0, 1) == "//") begin
                // Rest of a comment line
                c = $fgetc(fd);
                while (c != NEWLINE && c != -1) begin
                    c = $fgetc(fd);
                end
            end else begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h", case_start[num_cases],
                            case_end[num_cases], case_stride[num_cases],
                            case_pointer[num_cases], case_left[num_cases],
                            case_amount[num_cases], case_pop[num_cases]);
                if (n != 7) begin
                    $display("Case %s in the case file has missing columns", word);
                    error_count++;
                    break;
                end
                case_name[num_cases] = word;
                num_cases++;
            end
        end
        $fclose(fd);
        if (num_cases == 0) begin
            $display("No test cases were read from the case file");
            error_count++;
        end
    endtask

    task automatic finish_test(input int errors_before);
        if (error_count == errors_before) begin
            $display("Test %s: passed, %0d requests", test_name, received);
        end else begin
            $display("Test %s: failed with %0d errors", test_name, error_count - errors_before);
            failed_tests++;
        end
    endtask

    // ---------------------------------------------------------------------------
    // One test: start, configuration fetch, generation and drain
    // ---------------------------------------------------------------------------
    task automatic run_case(input int k);
        int errors_before;
        int n_items;
        int i;
        errors_before = error_count;
        test_name     = case_name[k];
        cur_pointer   = case_pointer[k];
        cur_left      = case_left[k];
        cur_amount    = case_amount[k];
        n_items       = item_count(case_start[k], case_end[k], case_stride[k]);
        expected_q.delete();
        for (i = 0; i < n_items; i++) begin
            expected_q.push_back(case_start[k] + index_t'(i) * case_stride[k]);
        end
        received   = 0;
        cfg_pulses = 0;
        hold_left  = case_pop[k][15:0];
        pop_random = case_pop[k][16];

        start = 1'b1;
        cycle_step();
        start = 1'b0;
        // No fetch while cfg_ready is low
        repeat (4) cycle_step();
        check_value("cfg_request before cfg_ready", 0, cfg_pulses);
        cfg_ready = 1'b1;
        while (cfg_pulses == 0) begin
            cycle_step();
        end
        cfg_valid         = 1'b1;
        cfg_index_start   = case_start[k];
        cfg_index_end     = case_end[k];
        cfg_stride        = case_stride[k];
        cfg_array_pointer = case_pointer[k];
        cfg_shift_left    = case_left[k];
        cfg_shift_amount  = case_amount[k];
        cycle_step();
        cfg_valid = 1'b0;
        cfg_ready = 1'b0;

        while (done) begin
            cycle_step();
        end
        while (!done) begin
            cycle_step();
        end

        // Generation is over, pop until the FIFO runs dry
        hold_left  = 0;
        pop_random = 1'b0;
        cycle_step();
        check_value("done after the last index", 1, done);
        do begin
            cycle_step();
            check_value("done after the last index", 1, done);
        end while (req_valid);

        check_value("request count", n_items, received);
        check_value("cfg_request cycles", 1, cfg_pulses);
        finish_test(errors_before);
    endtask

    initial begin
        int k;
        areset            = 1'b1;
        start             = 1'b0;
        cfg_ready         = 1'b0;
        cfg_valid         = 1'b0;
        cfg_index_start   = '0;
        cfg_index_end     = '0;
        cfg_stride        = '0;
        cfg_array_pointer = '0;
        cfg_shift_left    = 1'b0;
        cfg_shift_amount  = '0;
        req_rd_en         = 1'b0;
        lfsr_state        = 32'hc6ec8493;
        error_count       = 0;
        failed_tests      = 0;
        hold_left         = 0;
        pop_random        = 1'b0;
        received          = 0;
        cfg_pulses        = 0;
        test_name         = "reset";
        cases_loaded      = 1'b0;

        load_cases();
        watchdog_cycles = 2 * RESET_CYCLES + CYCLES_PER_TEST;
        for (k = 0; k < num_cases; k++) begin
            watchdog_cycles += CYCLES_PER_TEST + int'(case_pop[k][15:0])
                + CYCLES_PER_ITEM * item_count(case_start[k], case_end[k], case_stride[k]);
        end
        cases_loaded = 1'b1;

        repeat (RESET_CYCLES) @(negedge ap_clk);
        areset = 1'b0;

        // Idle outputs after reset
        repeat (8) begin
            cycle_step();
            check_value("done", 1, done);
            check_value("req_valid", 0, req_valid);
            check_value("cfg_request", 0, cfg_request);
        end
        finish_test(0);

        for (k = 0; k < num_cases; k++) begin
            run_case(k);
            repeat (2) cycle_step();
        end

        $display("Tests: %0d run, %0d failed, %0d check errors", num_cases + 1, failed_tests,
                 error_count);
        if (error_count == 0 && failed_tests == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the expected items of all tests
    initial begin
        wait (cases_loaded === 1'b1);
        repeat (watchdog_cycles) @(posedge ap_clk);
        $display("Timeout: no end after %0d cycles in test %s, control FSM in state %s",
                 watchdog_cycles, test_name, fsm_state.name());
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule : csr_index_generator_tb

// ==== tb/index_gen_cases.txt ====
// Test cases for the CSR index generator, all values in hex
// Columns: name, start, end, stride, array pointer, shift left (1) or right (0),
// shift amount, pop pattern (bits 15:0 cycles without pops after start,
// bit 16 set for random pops afterwards, clear for a pop every cycle)
unit_step     00000000 00000010 00000001 0000000080000000 1 02 00000
stride_three  00000005 00000029 00000003 0000000012340000 1 03 10000
shift_right   00000100 00000180 00000010 00000000deadbe00 0 04 10000
empty_range   00000040 00000040 00000001 0000000000001000 1 02 00000
start_above   00000090 00000020 00000004 0000000000002000 0 01 00000
held_random   00000000 00000030 00000001 0000000100000000 1 03 100c8
held_always   00000010 00000050 00000002 0000000000400000 0 00 00064
top_of_range  ffffff00 ffffffff 00000040 0000000000008000 1 01 10000
single_item   00000007 00000008 00000005 fedcba9876543210 1 1f 00000
large_stride  00001000 00100000 00040000 0000123400000000 0 08 10000
long_run      00000003 00000103 00000004 00000000cafe0000 1 05 10020

// ==== csr_index_generator.f ====
+incdir+include
source/index_gen_pkg.sv
source/index_gen_control.sv
source/index_sequencer.sv
source/request_fifo.sv
source/csr_index_generator.sv
tb/csr_index_generator_tb.sv

// ==== Bender.yml ====
package:
  name: csr_index_generator

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/index_gen_pkg.sv
      - source/index_gen_control.sv
      - source/index_sequencer.sv
      - source/request_fifo.sv
      - source/csr_index_generator.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/csr_index_generator_tb.sv
